/* verilog/slc3_macros.svh */
`ifndef SLC3_MACROS_SVH
`define SLC3_MACROS_SVH

// Word and register file geometry
`define WORD_W     16
`define REG_CNT    8
`define REG_SEL_W  3

// Select widths
`define PCSEL_W    2
`define DRSEL_W    2
`define ADDR2SEL_W 3

// PC source
`define PC_INC     2'd0
`define PC_BUS     2'd1
`define PC_ADDER   2'd2

// Destination register source
`define DR_IR      2'd0
`define DR_LOAD    2'd1
`define DR_R7      2'd2

// Second operand and address offset source
`define A2_SR2     3'd0
`define A2_IMM5    3'd1
`define A2_OFF9    3'd2
`define A2_OFF11   3'd3
`define A2_OFF6    3'd4

`endif

/* verilog/slc3Pkg.sv */
package slc3Pkg;

	// Instruction field IR[15:12]
	typedef enum logic [3:0] {
		opBr    = 4'b0000,
		opAdd   = 4'b0001,
		opJsr   = 4'b0100,
		opAnd   = 4'b0101,
		opLdr   = 4'b0110,
		opStr   = 4'b0111,
		opNot   = 4'b1001,
		opJmp   = 4'b1100,
		opPause = 4'b1101
	} opcodeT;

	// Sequencer states
	typedef enum logic [4:0] {
		sHalted,
		sFetchMar,      // MAR <- PC, PC + 1
		sFetchRd1,
		sFetchRd2,      // MDR <- memory
		sFetchIr,
		sDecode,
		sAdd,
		sAnd,
		sNot,
		sBr,
		sBrTaken,
		sJmp,
		sJsr1,          // R7 <- PC
		sJsr2,
		sLdrAddr,
		sLdrRd1,
		sLdrRd2,
		sLdrReg,
		sStrAddr,
		sStrMdr,
		sStrWr1,
		sStrWr2,
		sPause1,        // Wait for cont high
		sPause2         // Wait for cont low
	} seqStateT;

endpackage

/* verilog/controlSequencer.sv */
`include "slc3_macros.svh"

module controlSequencer (
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   run,
	input  logic                   cont,
	input  slc3Pkg::opcodeT        opcode,
	input  logic                   ir5,
	input  logic                   ir11,
	input  logic                   ben,
	output logic                   ldMar,
	output logic                   ldMdr,
	output logic                   ldIr,
	output logic                   ldBen,
	output logic                   ldReg,
	output logic                   ldPc,
	output logic                   ldLed,
	output logic [`PCSEL_W-1:0]    pcSel,
	output logic [`DRSEL_W-1:0]    drSel,
	output logic                   marSel,
	output logic                   mdrSel,
	output logic                   addr1Sel,
	output logic [`ADDR2SEL_W-1:0] addr2Sel,
	output logic                   memOeN,
	output logic                   memWeN,
	output logic                   paused
);
	import slc3Pkg::*;

	seqStateT state, nextState;

	always_ff @(posedge Clk)
	begin
		if (!rstN)
			state <= sHalted;
		else
			state <= nextState;
	end

	// ------------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------------
	always_comb
	begin
		nextState = state;
		unique case (state)
			sHalted:
				if (run)
					nextState = sFetchMar;
			sFetchMar: nextState = sFetchRd1;
			sFetchRd1: nextState = sFetchRd2;
			sFetchRd2: nextState = sFetchIr;
			sFetchIr:  nextState = sDecode;
			sDecode:
			begin
				case (opcode)
					opAdd:   nextState = sAdd;
					opAnd:   nextState = sAnd;
					opNot:   nextState = sNot;
					opBr:    nextState = sBr;
					opJmp:   nextState = sJmp;
					opJsr:   nextState = sJsr1;
					opLdr:   nextState = sLdrAddr;
					opStr:   nextState = sStrAddr;
					opPause: nextState = sPause1;
					default: nextState = sFetchMar;   // Unknown opcode is skipped
				endcase
			end
			sBr:
				if (ben)
					nextState = sBrTaken;
				else
					nextState = sFetchMar;
			sJsr1:    nextState = sJsr2;
			sLdrAddr: nextState = sLdrRd1;
			sLdrRd1:  nextState = sLdrRd2;
			sLdrRd2:  nextState = sLdrReg;
			sStrAddr: nextState = sStrMdr;
			sStrMdr:  nextState = sStrWr1;
			sStrWr1:  nextState = sStrWr2;
			sPause1:
				if (cont)
					nextState = sPause2;
			sPause2:
				if (!cont)
					nextState = sFetchMar;
			// Single cycle execute steps
			sAdd, sAnd, sNot, sBrTaken, sJmp, sJsr2, sLdrReg, sStrWr2:
				nextState = sFetchMar;
			default:
				nextState = sHalted;
		endcase
	end

	// ------------------------------------------------------------------------
	// Control outputs
	// ------------------------------------------------------------------------
	always_comb
	begin
		ldMar    = 1'b0;
		ldMdr    = 1'b0;
		ldIr     = 1'b0;
		ldBen    = 1'b0;
		ldReg    = 1'b0;
		ldPc     = 1'b0;
		ldLed    = 1'b0;
		pcSel    = `PC_INC;
		drSel    = `DR_IR;
		marSel   = 1'b0;     // PC
		mdrSel   = 1'b0;     // Memory data
		addr1Sel = 1'b0;     // Base register
		addr2Sel = `A2_SR2;
		memOeN   = 1'b1;
		memWeN   = 1'b1;
		paused   = 1'b0;

		case (state)
			sFetchMar:
			begin
				ldMar = 1'b1;
				ldPc  = 1'b1;
				pcSel = `PC_INC;
			end
			sFetchRd1, sLdrRd1:
				memOeN = 1'b0;
			sFetchRd2, sLdrRd2:
			begin
				memOeN = 1'b0;
				ldMdr  = 1'b1;
			end
			sFetchIr:
				ldIr = 1'b1;
			sDecode:
				ldBen = 1'b1;
			sAdd, sAnd:
			begin
				ldReg    = 1'b1;
				drSel    = `DR_IR;
				addr2Sel = ir5 ? `A2_IMM5 : `A2_SR2;   // Immediate form
			end
			sNot:
				ldReg = 1'b1;
			sBrTaken:
			begin
				ldPc     = 1'b1;
				pcSel    = `PC_ADDER;
				addr1Sel = 1'b1;
				addr2Sel = `A2_OFF9;
			end
			sJmp:
			begin
				ldPc  = 1'b1;
				pcSel = `PC_BUS;    // Base register through the ALU
			end
			sJsr1:
			begin
				ldReg = 1'b1;
				drSel = `DR_R7;
			end
			sJsr2:
			begin
				ldPc = 1'b1;
				if (ir11)
				begin
					pcSel    = `PC_ADDER;
					addr1Sel = 1'b1;
					addr2Sel = `A2_OFF11;
				end
				else
					pcSel = `PC_BUS;
			end
			sLdrAddr, sStrAddr:
			begin
				ldMar    = 1'b1;
				marSel   = 1'b1;
				addr2Sel = `A2_OFF6;
			end
			sLdrReg:
			begin
				ldReg = 1'b1;
				drSel = `DR_LOAD;
			end
			sStrMdr:
			begin
				ldMdr  = 1'b1;
				mdrSel = 1'b1;      // Source register IR[11:9]
			end
			sStrWr1, sStrWr2:
				memWeN = 1'b0;
			sPause1:
			begin
				ldLed  = 1'b1;
				paused = 1'b1;
			end
			sPause2:
				paused = 1'b1;
			default: ;
		endcase
	end

endmodule

/* verilog/regFile.sv */
`include "slc3_macros.svh"

module regFile (
	input  logic                  Clk,
	input  logic                  rstN,
	input  logic                  we,
	input  logic [`REG_SEL_W-1:0] wrSel,
	input  logic [`WORD_W-1:0]    wrData,
	input  logic [`REG_SEL_W-1:0] srcASel,
	input  logic [`REG_SEL_W-1:0] srcBSel,
	output logic [`WORD_W-1:0]    srcA,
	output logic [`WORD_W-1:0]    srcB
);

	logic [`WORD_W-1:0] regs [`REG_CNT];

	// Eight general registers
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[wrSel] <= wrData;
		end
	end

	// Combinational read ports
	assign srcA = regs[srcASel];
	assign srcB = regs[srcBSel];

endmodule

/* verilog/datapath.sv */
`include "slc3_macros.svh"

module datapath (
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   ldMar,
	input  logic                   ldMdr,
	input  logic                   ldIr,
	input  logic                   ldBen,
	input  logic                   ldReg,
	input  logic                   ldPc,
	input  logic                   ldLed,
	input  logic [`PCSEL_W-1:0]    pcSel,
	input  logic [`DRSEL_W-1:0]    drSel,
	input  logic                   marSel,
	input  logic                   mdrSel,
	input  logic                   addr1Sel,
	input  logic [`ADDR2SEL_W-1:0] addr2Sel,
	input  logic [`WORD_W-1:0]     memRData,
	output slc3Pkg::opcodeT        opcode,
	output logic                   ir5,
	output logic                   ir11,
	output logic                   ben,
	output logic [`WORD_W-1:0]     memAddr,
	output logic [`WORD_W-1:0]     memWData,
	output logic [11:0]            ledOut
);
	import slc3Pkg::*;

	logic [`WORD_W-1:0]    pc, ir, mar, mdr;
	logic [2:0]            nzp;
	logic [`WORD_W-1:0]    srcA, srcB;
	logic [`WORD_W-1:0]    offset, base, adderOut, aluOut, bus;
	logic [`REG_SEL_W-1:0] wrSel, srcBSel;

	assign opcode   = opcodeT'(ir[15:12]);
	assign ir5      = ir[5];
	assign ir11     = ir[11];
	assign memAddr  = mar;
	assign memWData = mdr;

	// ------------------------------------------------------------------------
	// Arithmetic path
	// ------------------------------------------------------------------------
	assign wrSel   = (drSel == `DR_R7) ? 3'd7 : ir[11:9];
	assign srcBSel = mdrSel ? ir[11:9] : ir[2:0];   // SR of STR

	regFile u_regFile (
		.Clk     (Clk),
		.rstN    (rstN),
		.we      (ldReg),
		.wrSel   (wrSel),
		.wrData  (bus),
		.srcASel (ir[8:6]),
		.srcBSel (srcBSel),
		.srcA    (srcA),
		.srcB    (srcB)
	);

	// Offset select also supplies the second ALU operand
	always_comb
	begin
		case (addr2Sel)
			`A2_IMM5:  offset = {{(`WORD_W-5){ir[4]}}, ir[4:0]};
			`A2_OFF9:  offset = {{(`WORD_W-9){ir[8]}}, ir[8:0]};
			`A2_OFF11: offset = {{(`WORD_W-11){ir[10]}}, ir[10:0]};
			`A2_OFF6:  offset = {{(`WORD_W-6){ir[5]}}, ir[5:0]};
			default:   offset = srcB;
		endcase
	end

	always_comb
	begin
		case (opcode)
			opAdd:   aluOut = srcA + offset;
			opAnd:   aluOut = srcA & offset;
			opNot:   aluOut = ~srcA;
			default: aluOut = srcA;    // JMP and JSRR pass the base register
		endcase
	end

	// ------------------------------------------------------------------------
	// Address path
	// ------------------------------------------------------------------------
	assign base     = addr1Sel ? pc : srcA;
	assign adderOut = base + offset;

	// Bus select follows whichever register is loading
	always_comb
	begin
		if (ldReg)
		begin
			case (drSel)
				`DR_LOAD: bus = mdr;
				`DR_R7:   bus = pc;         // Return address
				default:  bus = aluOut;
			endcase
		end
		else if (ldMar)
			bus = marSel ? adderOut : pc;
		else
			bus = aluOut;
	end

	// ------------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			pc     <= '0;
			ir     <= '0;
			nzp    <= 3'b000;
			ben    <= 1'b0;
			ledOut <= '0;
		end
		else
		begin
			if (ldPc)
			begin
				case (pcSel)
					`PC_BUS:   pc <= bus;
					`PC_ADDER: pc <= adderOut;
					default:   pc <= pc + 1'b1;
				endcase
			end
			if (ldIr)
				ir <= mdr;
			if (ldReg)
				nzp <= {bus[`WORD_W-1], bus == '0, !bus[`WORD_W-1] && bus != '0};
			if (ldBen)
				ben <= |(ir[11:9] & nzp);    // Branch condition mask
			if (ldLed)
				ledOut <= ir[11:0];
		end
	end

	// Memory address and data registers
	always_ff @(posedge Clk)
	begin
		if (ldMar)
			mar <= bus;
		if (ldMdr)
			mdr <= mdrSel ? srcB : memRData;
	end

endmodule

/* verilog/slc3Top.sv */
`include "slc3_macros.svh"

module slc3Top (
	input  logic               Clk,
	input  logic               rstN,
	input  logic               run,
	input  logic               cont,
	input  logic [`WORD_W-1:0] memRData,
	output logic [`WORD_W-1:0] memAddr,
	output logic [`WORD_W-1:0] memWData,
	output logic               memOeN,
	output logic               memWeN,
	output logic [11:0]        ledOut,
	output logic               paused
);
	import slc3Pkg::*;

	// Sequencer controls
	logic                   ldMar, ldMdr, ldIr, ldBen, ldReg, ldPc, ldLed;
	logic [`PCSEL_W-1:0]    pcSel;
	logic [`DRSEL_W-1:0]    drSel;
	logic                   marSel, mdrSel, addr1Sel;
	logic [`ADDR2SEL_W-1:0] addr2Sel;

	// Datapath status
	opcodeT                 opcode;
	logic                   ir5, ir11, ben;

	controlSequencer u_seq (
		.Clk      (Clk),
		.rstN     (rstN),
		.run      (run),
		.cont     (cont),
		.opcode   (opcode),
		.ir5      (ir5),
		.ir11     (ir11),
		.ben      (ben),
		.ldMar    (ldMar),
		.ldMdr    (ldMdr),
		.ldIr     (ldIr),
		.ldBen    (ldBen),
		.ldReg    (ldReg),
		.ldPc     (ldPc),
		.ldLed    (ldLed),
		.pcSel    (pcSel),
		.drSel    (drSel),
		.marSel   (marSel),
		.mdrSel   (mdrSel),
		.addr1Sel (addr1Sel),
		.addr2Sel (addr2Sel),
		.memOeN   (memOeN),
		.memWeN   (memWeN),
		.paused   (paused)
	);

	datapath u_datapath (
		.Clk      (Clk),
		.rstN     (rstN),
		.ldMar    (ldMar),
		.ldMdr    (ldMdr),
		.ldIr     (ldIr),
		.ldBen    (ldBen),
		.ldReg    (ldReg),
		.ldPc     (ldPc),
		.ldLed    (ldLed),
		.pcSel    (pcSel),
		.drSel    (drSel),
		.marSel   (marSel),
		.mdrSel   (mdrSel),
		.addr1Sel (addr1Sel),
		.addr2Sel (addr2Sel),
		.memRData (memRData),
		.opcode   (opcode),
		.ir5      (ir5),
		.ir11     (ir11),
		.ben      (ben),
		.memAddr  (memAddr),
		.memWData (memWData),
		.ledOut   (ledOut)
	);

endmodule

/* bench/sramModel.sv */
`include "slc3_macros.svh"

module sramModel (
	input  logic               oeN,
	input  logic               weN,
	input  logic [`WORD_W-1:0] addr,
	input  logic [`WORD_W-1:0] wData,
	output logic [`WORD_W-1:0] rData
);
	timeunit 1ns;
	timeprecision 1ps;

	// 256 words on the low address byte
	logic [`WORD_W-1:0] mem [256];

	// Word is captured as the write strobe rises
	always @(posedge weN)
	begin
		mem[addr[7:0]] <= wData;
	end

	assign rData = oeN ? '0 : mem[addr[7:0]];   // No wait states

endmodule

/* bench/slc3Tb.sv */
`include "slc3_macros.svh"

module slc3Tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int EV_MAX   = 32;
	localparam int EV_STORE = 0;
	localparam int EV_PAUSE = 1;

	logic               Clk;
	logic               rstN;
	logic               run;
	logic               cont;
	logic [`WORD_W-1:0] memRData;
	logic [`WORD_W-1:0] memAddr;
	logic [`WORD_W-1:0] memWData;
	logic               memOeN;
	logic               memWeN;
	logic [11:0]        ledOut;
	logic               paused;

	// Program loading path into the memory
	logic               loading;
	logic               loadWeN;
	logic [`WORD_W-1:0] loadAddr;
	logic [`WORD_W-1:0] loadData;
	logic [`WORD_W-1:0] sramAddr;
	logic [`WORD_W-1:0] sramWData;
	logic               sramWeN;

	logic [`WORD_W-1:0] image [256];
	int                 evKind [EV_MAX];
	logic [`WORD_W-1:0] evAddr [EV_MAX];
	logic [`WORD_W-1:0] evData [EV_MAX];
	int                 evCount;
	int                 testCount;
	int                 failCount;
	int                 errors;
	logic [31:0]        rngState;

	slc3Top u_dut (
		.Clk      (Clk),
		.rstN     (rstN),
		.run      (run),
		.cont     (cont),
		.memRData (memRData),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memOeN   (memOeN),
		.memWeN   (memWeN),
		.ledOut   (ledOut),
		.paused   (paused)
	);

	assign sramAddr  = loading ? loadAddr : memAddr;
	assign sramWData = loading ? loadData : memWData;
	assign sramWeN   = loading ? loadWeN : memWeN;

	sramModel u_sram (
		.oeN   (memOeN),
		.weN   (sramWeN),
		.addr  (sramAddr),
		.wData (sramWData),
		.rData (memRData)
	);

	always
		#5 Clk = ~Clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Count in 1..span
	task automatic drawCycles(input int span, output int n);
		rngState = xorshift(rngState);
		n = 1 + int'(rngState[7:0]) % span;
	endtask

	// Unused words hold an undefined opcode tagged with their address
	task automatic fillImage();
		for (int i = 0; i < 256; i++)
			image[i] = {8'hF0, i[7:0]};
	endtask

	// ------------------------------------------------------------------------
	// Reset, then memory load while halted
	// ------------------------------------------------------------------------
	task automatic prepareTest();
		@(negedge Clk);
		rstN    = 1'b0;
		run     = 1'b0;
		cont    = 1'b0;
		loadWeN = 1'b1;
		loading = 1'b1;
		repeat (3) @(negedge Clk);
		rstN = 1'b1;
		for (int i = 0; i < 256; i++)
		begin
			@(negedge Clk);
			loadAddr = 16'(i);
			loadData = image[i];
			loadWeN  = 1'b0;
			@(negedge Clk);
			loadWeN  = 1'b1;    // Write on the rising strobe
		end
		@(negedge Clk);
		loading = 1'b0;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errors == 0)
			$display("Test %s ok", name);
		else
		begin
			$display("Test %s failed with %0d errors", name, errors);
			failCount++;
		end
	endtask

	task automatic checkReset();
		errors = 0;
		fillImage();
		prepareTest();
		for (int i = 0; i < 20; i++)
		begin
			@(negedge Clk);
			if ({memOeN, memWeN, paused} !== 3'b110)
			begin
				$display("Fail reset strobes: expected %b, actual %b", 3'b110,
					{memOeN, memWeN, paused});
				errors++;
			end
			if (ledOut !== 12'h000)
			begin
				$display("Fail reset ledOut: expected %h, actual %h", 12'h000, ledOut);
				errors++;
			end
		end
		finishTest("reset");
	endtask

	// ------------------------------------------------------------------------
	// Event handling
	// ------------------------------------------------------------------------
	task automatic awaitEvent(output int kind);
		int waited;
		kind   = -1;
		waited = 0;
		while (kind < 0 && waited < 400)
		begin
			@(negedge Clk);
			waited++;
			if (memWeN == 1'b0)
				kind = EV_STORE;
			else if (paused)
				kind = EV_PAUSE;
		end
	endtask

	task automatic checkStore(input string name, input int e);
		int waited;
		if (memAddr !== evAddr[e])
		begin
			$display("Fail %s store address: expected %h, actual %h", name, evAddr[e], memAddr);
			errors++;
		end
		if (memWData !== evData[e])
		begin
			$display("Fail %s store data: expected %h, actual %h", name, evData[e], memWData);
			errors++;
		end
		waited = 0;
		while (memWeN == 1'b0 && waited < 8)
		begin
			@(negedge Clk);
			waited++;
		end
		if (waited != 2)
		begin
			$display("%s: write strobe was low for %0d cycles instead of 2", name, waited);
			errors++;
		end
	endtask

	task automatic checkPause(input string name, input int e);
		int lowCycles;
		int highCycles;
		int waited;
		@(negedge Clk);     // LED register loads one cycle in
		if (ledOut !== evData[e][11:0])
		begin
			$display("Fail %s ledOut: expected %h, actual %h", name, evData[e][11:0], ledOut);
			errors++;
		end
		drawCycles(4, lowCycles);
		drawCycles(8, highCycles);
		for (int i = 0; i < lowCycles; i++)
		begin
			@(negedge Clk);
			if (!paused)
			begin
				$display("%s: pause ended before cont rose", name);
				errors++;
			end
		end
		cont = 1'b1;
		for (int i = 0; i < highCycles; i++)
		begin
			@(negedge Clk);
			if (!paused)
			begin
				$display("%s: pause ended while cont was still high", name);
				errors++;
			end
		end
		cont   = 1'b0;
		waited = 0;
		while (paused && waited < 8)
		begin
			@(negedge Clk);
			waited++;
		end
		if (paused)
		begin
			$display("%s: program did not resume after cont fell", name);
			errors++;
		end
	endtask

	task automatic checkIdle(input string name);
		logic busy;
		busy = 1'b0;
		for (int i = 0; i < 40; i++)
		begin
			@(negedge Clk);
			if (!memWeN || paused)
				busy = 1'b1;
		end
		if (busy)
		begin
			$display("%s: store or pause seen after the last expected event", name);
			errors++;
		end
	endtask

	task automatic runTest(input string name);
		int   kind;
		logic aborted;
		errors  = 0;
		aborted = 1'b0;
		prepareTest();
		@(negedge Clk);
		run = 1'b1;
		@(negedge Clk);
		run = 1'b0;
		for (int e = 0; e < evCount; e++)
		begin
			if (!aborted)
			begin
				awaitEvent(kind);
				if (kind < 0)
				begin
					$display("%s: timed out waiting for event %0d", name, e);
					errors++;
					aborted = 1'b1;
				end
				else if (kind != evKind[e])
				begin
					$display("Fail %s event %0d: expected %s, actual %s", name, e,
						(evKind[e] == EV_STORE) ? "store" : "pause",
						(kind == EV_STORE) ? "store" : "pause");
					errors++;
					aborted = 1'b1;
				end
				else if (kind == EV_STORE)
					checkStore(name, e);
				else
					checkPause(name, e);
			end
		end
		if (!aborted)
			checkIdle(name);
		finishTest(name);
	endtask

	// ------------------------------------------------------------------------
	// Golden file
	// ------------------------------------------------------------------------
	task automatic addEvent(input int kind, input logic [`WORD_W-1:0] a,
		input logic [`WORD_W-1:0] d);
		if (evCount < EV_MAX)
		begin
			evKind[evCount] = kind;
			evAddr[evCount] = a;
			evData[evCount] = d;
			evCount++;
		end
		else
		begin
			$display("Too many events in one test of the golden file");
			failCount++;
		end
	endtask

	task automatic flagBadRecord(input string key);
		$display("Malformed %s record in the golden file", key);
		failCount++;
	endtask

	task automatic readGolden();
		int                 fd;
		int                 code;
		int                 ch;
		string              key;
		string              name;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] d;
		name = "unnamed";
		fd   = $fopen("bench/slc3_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open bench/slc3_golden.txt");
			failCount++;
		end
		else
		begin
			while ($fscanf(fd, "%s", key) == 1)
			begin
				if (key == "#")
				begin
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1)    // Skip to end of line
						ch = $fgetc(fd);
				end
				else if (key == "test")
				begin
					code    = $fscanf(fd, "%s", name);
					if (code != 1)
						flagBadRecord(key);
					evCount = 0;
					fillImage();
				end
				else if (key == "mem")
				begin
					code = $fscanf(fd, "%h %h", a, d);
					if (code != 2)
						flagBadRecord(key);
					image[a[7:0]] = d;
				end
				else if (key == "store")
				begin
					code = $fscanf(fd, "%h %h", a, d);
					if (code != 2)
						flagBadRecord(key);
					addEvent(EV_STORE, a, d);
				end
				else if (key == "pause")
				begin
					code = $fscanf(fd, "%h", d);
					if (code != 1)
						flagBadRecord(key);
					addEvent(EV_PAUSE, '0, d);
				end
				else if (key == "end")
					runTest(name);
				else
				begin
					$display("Unknown keyword %s in the golden file", key);
					failCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		Clk       = 1'b0;
		rstN      = 1'b1;
		run       = 1'b0;
		cont      = 1'b0;
		loading   = 1'b1;
		loadWeN   = 1'b1;
		loadAddr  = '0;
		loadData  = '0;
		evCount   = 0;
		testCount = 0;
		failCount = 0;
		errors    = 0;
		rngState  = 32'd92209;

		checkReset();
		readGolden();

		$display("Tests run: %0d, failed: %0d", testCount, failCount);
		if (failCount == 0 && testCount > 1)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* bench/slc3_golden.txt */
# Records: test <name> | mem <addr> <word> | store <addr> <data> | pause <led> | end
# All values hex; events are listed in the order the program must produce them
test arith
mem 00 6C1E
mem 01 621F
mem 02 641D
mem 03 1642
mem 04 7780
mem 05 187B
mem 06 7981
mem 07 5A42
mem 08 7B82
mem 09 967F
mem 0A 7783
mem 0B 5A67
mem 0C 7B84
mem 0D 0FFF
mem 1D 0F0F
mem 1E 0040
mem 1F 1234
store 0040 2143
store 0041 122F
store 0042 0204
store 0043 EDCB
store 0044 0004
end
test loadstore
mem 00 6C1E
mem 01 621C
mem 02 7385
mem 03 641D
mem 04 72BD
mem 05 6785
mem 06 16E1
mem 07 7680
mem 08 0FFF
mem 1C BEEF
mem 1D 0050
mem 1E 0040
store 0045 BEEF
store 004D BEEF
store 0050 BEF0
end
test branch
mem 00 6C1E
mem 01 5260
mem 02 0401
mem 03 7D80
mem 04 1261
mem 05 0C01
mem 06 7381
mem 07 4804
mem 08 1462
mem 09 7583
mem 0A 681D
mem 0B C100
mem 0C 7F82
mem 0D C1C0
mem 0E 7D84
mem 12 7985
mem 13 0FFF
mem 1D 0012
mem 1E 0040
store 0041 0001
store 0042 0008
store 0043 0003
store 0045 0012
end
test pause
mem 00 6C1E
mem 01 DA5C
mem 02 7D80
mem 03 D123
mem 04 13BF
mem 05 7381
mem 06 0FFF
mem 1E 0040
pause A5C
store 0040 0040
pause 123
store 0041 003F
end

/* tb.f */
+incdir+verilog
verilog/slc3Pkg.sv
verilog/controlSequencer.sv
verilog/regFile.sv
verilog/datapath.sv
verilog/slc3Top.sv
bench/sramModel.sv
bench/slc3Tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module slc3Tb -f tb.f -Mdir obj_dir
	@out=$$(./obj_dir/Vslc3Tb); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
